/* sources.f */
src/rv_pkg.sv
src/regfile.sv
src/decoder.sv
src/id_ex.sv
src/id_stage.sv
src/ex_alu.sv
src/decode_execute_top.sv
tb/tb_checker.sv
tb/tb_top.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_top
FILELIST  = sources.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Everything OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb/tb_top.sv */
// --------------------------------------------------------------------------
// Testbench for the RV64I decode/execute slice.
// Random instruction stream with hold injection, checker and watchdog.
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module tb_top;
	import rv_pkg::*;

	localparam int N_INSTR    = 400;
	localparam int CLK_PERIOD = 4;
	localparam int TIMEOUT_NS = (2 * N_INSTR + 40) * CLK_PERIOD;

	logic                  clk;
	logic                  rst_n_i;
	hold_code_e            hold_code_i;
	logic [INSTR_W-1:0]    instr_i;
	logic [XLEN-1:0]       addr_instr_i;
	logic                  jmp_flag_o;
	logic [XLEN-1:0]       jmp_target_o;
	logic                  wb_en_o;
	logic [REG_ADDR_W-1:0] wb_addr_o;
	logic [XLEN-1:0]       wb_data_o;
	int                    jmp_errs, wb_errs, wb_checked;
	int                    seed;
	int                    accepted;
	logic [XLEN-1:0]       pc;

	decode_execute_top uut (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.hold_code_i  (hold_code_i),
		.instr_i      (instr_i),
		.addr_instr_i (addr_instr_i),
		.jmp_flag_o   (jmp_flag_o),
		.jmp_target_o (jmp_target_o),
		.wb_en_o      (wb_en_o),
		.wb_addr_o    (wb_addr_o),
		.wb_data_o    (wb_data_o)
	);

	tb_checker chk (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.hold_code_i  (hold_code_i),
		.instr_i      (instr_i),
		.addr_instr_i (addr_instr_i),
		.jmp_flag_i   (jmp_flag_o),
		.jmp_target_i (jmp_target_o),
		.wb_en_i      (wb_en_o),
		.wb_addr_i    (wb_addr_o),
		.wb_data_i    (wb_data_o),
		.jmp_errs_o   (jmp_errs),
		.wb_errs_o    (wb_errs),
		.wb_checked_o (wb_checked)
	);

	// Mostly x0..x7 so that dependencies are frequent.
	function automatic logic [REG_ADDR_W-1:0] pick_reg();
		logic [31:0] r;
		r = $random(seed);
		if (r[7:5] == 3'b000) return r[4:0];
		return {2'b00, r[2:0]};
	endfunction

	function automatic hold_code_e pick_hold();
		logic [31:0] r;
		r = $random(seed);
		if (r[2:0] == 3'b000) begin
			if (r[3]) return HOLD_EX;
			return HOLD_ID;
		end
		if (r[4]) return HOLD_IF;
		return HOLD_NONE;
	endfunction

	function automatic logic [INSTR_W-1:0] build_instr();
		logic [31:0]           r, r2, kind;
		logic [REG_ADDR_W-1:0] rd, rs1, rs2;
		logic [2:0]            f3;
		logic [6:0]            opc;
		logic [INSTR_W-1:0]    ins;
		r    = $random(seed);
		r2   = $random(seed);
		kind = $unsigned($random(seed)) % 12;
		rd   = pick_reg();
		rs1  = pick_reg();
		rs2  = pick_reg();
		f3   = r2[2:0];
		case (kind)
			0: ins = {r[31:12], rd, 7'h37};
			1: ins = {r[31:12], rd, 7'h17};
			2: ins = {r[31:12], rd, 7'h6f};
			3: ins = {r[31:20], rs1, 3'b000, rd, 7'h67};
			4: begin
				if (f3 == 3'b010 || f3 == 3'b011) f3[2] = 1'b1;	// Valid branch codes only.
				ins = {r[31:25], rs2, rs1, f3, r[11:7], 7'h63};
			end
			5, 6: begin
				if (f3 == 3'b001) ins = {6'b000000, r[25:20], rs1, f3, rd, 7'h13};
				else if (f3 == 3'b101) ins = {1'b0, r2[3], 4'b0000, r[25:20], rs1, f3, rd, 7'h13};
				else ins = {r[31:20], rs1, f3, rd, 7'h13};
			end
			7, 8: ins = {1'b0, r2[3] && (f3 == 3'b000 || f3 == 3'b101), 5'b00000,
				rs2, rs1, f3, rd, 7'h33};
			9: begin
				f3 = r2[1] ? 3'b101 : {2'b00, r2[0]};
				if (f3 == 3'b000) ins = {r[31:20], rs1, f3, rd, 7'h1b};
				else if (f3 == 3'b001) ins = {7'b0000000, r[24:20], rs1, f3, rd, 7'h1b};
				else ins = {1'b0, r2[3], 5'b00000, r[24:20], rs1, f3, rd, 7'h1b};
			end
			10: begin
				f3  = r2[1] ? 3'b101 : {2'b00, r2[0]};
				ins = {1'b0, r2[3] && (f3 != 3'b001), 5'b00000, rs2, rs1, f3, rd, 7'h3b};
			end
			default: begin
				if (r2[1:0] == 2'b00) opc = 7'h03;	// Load.
				else if (r2[1:0] == 2'b01) opc = 7'h23;	// Store.
				else opc = 7'h73;
				ins = {r[31:7], opc};
			end
		endcase
		return ins;
	endfunction

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		seed         = 32'h5102b149;
		rst_n_i      = 1'b0;
		hold_code_i  = HOLD_NONE;
		instr_i      = '0;
		addr_instr_i = '0;
		accepted     = 0;
		pc           = 64'h0000_0000_0000_1000;
		repeat (4) @(posedge clk);
		rst_n_i      <= 1'b1;
		instr_i      <= build_instr();
		addr_instr_i <= pc;
		hold_code_i  <= pick_hold();
		while (accepted < N_INSTR) begin
			@(posedge clk);
			if (hold_code_i < HOLD_ID) begin	// Taken by decode at this edge.
				accepted++;
				pc = pc + 64'd4;
				addr_instr_i <= pc;
				if (accepted < N_INSTR) instr_i <= build_instr();
				else instr_i <= '0;
			end
			hold_code_i <= pick_hold();
		end
		hold_code_i <= HOLD_NONE;
		repeat (4) @(posedge clk);
		$display("Errors: %0d (jump %0d, write-back %0d), write-backs compared: %0d",
			jmp_errs + wb_errs, jmp_errs, wb_errs, wb_checked);
		if (jmp_errs == 0 && wb_errs == 0 && wb_checked > 0) begin
			$display("Everything OK");
		end else begin
			if (wb_checked == 0) $display("No write-back was ever compared.");
			$display("Something failed");
		end
		$finish;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("Timeout: the instruction stream did not finish within %0d ns", TIMEOUT_NS);
		$display("Something failed");
		$finish;
	end

endmodule

/* tb/tb_checker.sv */
// --------------------------------------------------------------------------
// Checker for the decode/execute slice.
// Sequential RV64I model, jump compare at acceptance and write-back
// compare two cycles after an instruction is presented.
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module tb_checker (
	input  logic                          clk,
	input  logic                          rst_n_i,
	input  rv_pkg::hold_code_e            hold_code_i,
	input  logic [rv_pkg::INSTR_W-1:0]    instr_i,
	input  logic [rv_pkg::XLEN-1:0]       addr_instr_i,
	input  logic                          jmp_flag_i,
	input  logic [rv_pkg::XLEN-1:0]       jmp_target_i,
	input  logic                          wb_en_i,
	input  logic [rv_pkg::REG_ADDR_W-1:0] wb_addr_i,
	input  logic [rv_pkg::XLEN-1:0]       wb_data_i,
	output int                            jmp_errs_o,
	output int                            wb_errs_o,
	output int                            wb_checked_o
);
	import rv_pkg::*;

	logic [XLEN-1:0]          model_regs [32];
	logic [XLEN+REG_ADDR_W:0] exp_q [$];	// One {en, rd, data} entry per cycle.
	int                       jmp_errs = 0;
	int                       wb_errs = 0;
	int                       wb_checked = 0;

	assign jmp_errs_o   = jmp_errs;
	assign wb_errs_o    = wb_errs;
	assign wb_checked_o = wb_checked;

	task automatic print_mismatch(input string name, input logic [XLEN-1:0] exp_val,
			input logic [XLEN-1:0] act_val);
		$display("ERR %s expected %0h got %0h at %0t", name, exp_val, act_val, $time);
	endtask

	function automatic logic [XLEN-1:0] alu_ref(input logic [2:0] f3, input logic alt,
			input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
		logic [XLEN-1:0] r;
		r = '0;
		case (f3)
			3'd0: begin
				if (alt) r = a - b;
				else r = a + b;
			end
			3'd1: r = a << b[5:0];
			3'd2: r[0] = ($signed(a) < $signed(b));
			3'd3: r[0] = (a < b);
			3'd4: r = a ^ b;
			3'd5: begin
				if (alt) r = $signed(a) >>> b[5:0];
				else r = a >> b[5:0];
			end
			3'd6: r = a | b;
			default: r = a & b;
		endcase
		return r;
	endfunction

	// 32-bit operation, result sign-extended from bit 31.
	function automatic logic [XLEN-1:0] word_ref(input logic [2:0] f3, input logic alt,
			input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
		logic [31:0] r;
		if (f3 == 3'd1) r = a[31:0] << b[4:0];
		else if (f3 == 3'd5 && alt) r = $signed(a[31:0]) >>> b[4:0];
		else if (f3 == 3'd5) r = a[31:0] >> b[4:0];
		else if (alt) r = a[31:0] - b[31:0];
		else r = a[31:0] + b[31:0];
		return {{32{r[31]}}, r};
	endfunction

	function automatic void expected_result(input logic [INSTR_W-1:0] ins,
			input logic [XLEN-1:0] pc, input logic [XLEN-1:0] regs [32],
			output logic en, output logic [REG_ADDR_W-1:0] rd,
			output logic [XLEN-1:0] res, output logic jflag, output logic [XLEN-1:0] jtgt);
		logic [2:0]      f3;
		logic [XLEN-1:0] rs1v, rs2v;
		logic [XLEN-1:0] imm_i, imm_u, imm_b, imm_j;
		logic            word_ok;
		f3      = ins[14:12];
		rd      = ins[11:7];
		rs1v    = regs[ins[19:15]];
		rs2v    = regs[ins[24:20]];
		imm_i   = {{52{ins[31]}}, ins[31:20]};
		imm_u   = {{32{ins[31]}}, ins[31:12], 12'h000};
		imm_b   = {{52{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
		imm_j   = {{44{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
		word_ok = (f3 == 3'd0) || (f3 == 3'd1) || (f3 == 3'd5);
		en      = 1'b0;
		res     = '0;
		jflag   = 1'b0;
		jtgt    = '0;
		case (ins[6:0])
			7'h37: begin	// LUI.
				en  = 1'b1;
				res = imm_u;
			end
			7'h17: begin	// AUIPC.
				en  = 1'b1;
				res = pc + imm_u;
			end
			7'h6f: begin	// JAL.
				en    = 1'b1;
				res   = pc + 64'd4;
				jflag = 1'b1;
				jtgt  = pc + imm_j;
			end
			7'h67: begin	// JALR.
				en    = 1'b1;
				res   = pc + 64'd4;
				jflag = 1'b1;
				jtgt  = (rs1v + imm_i) & ~64'd1;
			end
			7'h63: begin
				case (f3)
					3'd0: jflag = (rs1v == rs2v);
					3'd1: jflag = (rs1v != rs2v);
					3'd4: jflag = ($signed(rs1v) < $signed(rs2v));
					3'd5: jflag = ($signed(rs1v) >= $signed(rs2v));
					3'd6: jflag = (rs1v < rs2v);
					3'd7: jflag = (rs1v >= rs2v);
					default: jflag = 1'b0;
				endcase
				jtgt = pc + imm_b;
			end
			7'h13: begin
				en  = 1'b1;
				res = alu_ref(f3, (f3 == 3'd5) && ins[30], rs1v, imm_i);
			end
			7'h33: begin
				en  = 1'b1;
				res = alu_ref(f3, ins[30], rs1v, rs2v);
			end
			7'h1b: begin
				en  = word_ok;
				res = word_ref(f3, (f3 == 3'd5) && ins[30], rs1v, imm_i);
			end
			7'h3b: begin
				en  = word_ok;
				res = word_ref(f3, ins[30], rs1v, rs2v);
			end
			default: en = 1'b0;	// Loads, stores, system.
		endcase
		if (rd == '0) en = 1'b0;
	endfunction

	// Sampled at the falling edge where inputs and outputs are settled.
	always @(negedge clk) begin : compare
		logic [XLEN+REG_ADDR_W:0] item;
		logic                     en;
		logic [REG_ADDR_W-1:0]    rd;
		logic [XLEN-1:0]          res;
		logic                     jflag;
		logic [XLEN-1:0]          jtgt;
		if (!rst_n_i) begin
			exp_q.delete();
			for (int i = 0; i < 32; i++) begin
				model_regs[i] = '0;
			end
			if (wb_en_i !== 1'b0) begin
				print_mismatch("wb_en_o", '0, XLEN'(wb_en_i));
				wb_errs++;
			end
			if (wb_addr_i !== '0) begin
				print_mismatch("wb_addr_o", '0, XLEN'(wb_addr_i));
				wb_errs++;
			end
			if (wb_data_i !== '0) begin
				print_mismatch("wb_data_o", '0, wb_data_i);
				wb_errs++;
			end
		end else begin
			if (exp_q.size() == 2) begin
				item = exp_q.pop_front();
				if (wb_en_i !== item[XLEN+REG_ADDR_W]) begin
					print_mismatch("wb_en_o", XLEN'(item[XLEN+REG_ADDR_W]), XLEN'(wb_en_i));
					wb_errs++;
				end else if (item[XLEN+REG_ADDR_W]) begin
					wb_checked++;
					if (wb_addr_i !== item[XLEN+REG_ADDR_W-1:XLEN]) begin
						print_mismatch("wb_addr_o", XLEN'(item[XLEN+REG_ADDR_W-1:XLEN]),
							XLEN'(wb_addr_i));
						wb_errs++;
					end
					if (wb_data_i !== item[XLEN-1:0]) begin
						print_mismatch("wb_data_o", item[XLEN-1:0], wb_data_i);
						wb_errs++;
					end
				end
			end
			item = '0;
			if (hold_code_i < HOLD_ID) begin	// Accepted at the next rising edge.
				expected_result(instr_i, addr_instr_i, model_regs, en, rd, res, jflag, jtgt);
				if (jmp_flag_i !== jflag) begin
					print_mismatch("jmp_flag_o", XLEN'(jflag), XLEN'(jmp_flag_i));
					jmp_errs++;
				end else if (jflag && jmp_target_i !== jtgt) begin
					print_mismatch("jmp_target_o", jtgt, jmp_target_i);
					jmp_errs++;
				end
				if (en) model_regs[rd] = res;
				item = {en, rd, res};
			end
			exp_q.push_back(item);
		end
	end

endmodule

/* src/decode_execute_top.sv */
// --------------------------------------------------------------------------
// Decode and execute slice of an RV64I pipeline.
// Register file, decode stage and execute stage.
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module decode_execute_top (
	input  logic                          clk,
	input  logic                          rst_n_i,
	input  rv_pkg::hold_code_e            hold_code_i,
	input  logic [rv_pkg::INSTR_W-1:0]    instr_i,
	input  logic [rv_pkg::XLEN-1:0]       addr_instr_i,
	output logic                          jmp_flag_o,
	output logic [rv_pkg::XLEN-1:0]       jmp_target_o,
	output logic                          wb_en_o,
	output logic [rv_pkg::REG_ADDR_W-1:0] wb_addr_o,
	output logic [rv_pkg::XLEN-1:0]       wb_data_o
);
	import rv_pkg::*;

	logic [REG_ADDR_W-1:0] rs1_addr, rs2_addr;
	logic [XLEN-1:0]       rs1_data, rs2_data;
	logic [REG_ADDR_W-1:0] ex_rd;
	logic                  ex_wr_en;
	alu_op_e               alu_operation;
	logic                  word_intercept;
	logic [XLEN-1:0]       alu_op_num1, alu_op_num2;
	logic [XLEN-1:0]       ex_result;
	logic                  rf_wr_en;
	logic [REG_ADDR_W-1:0] rf_wr_addr;
	logic [XLEN-1:0]       rf_wr_data;

	regfile u_regfile (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.rs1_addr_i (rs1_addr),
		.rs2_addr_i (rs2_addr),
		.rs1_data_o (rs1_data),
		.rs2_data_o (rs2_data),
		.wr_en_i    (rf_wr_en),
		.wr_addr_i  (rf_wr_addr),
		.wr_data_i  (rf_wr_data)
	);

	id_stage u_id_stage (
		.clk              (clk),
		.rst_n_i          (rst_n_i),
		.hold_code_i      (hold_code_i),
		.instr_i          (instr_i),
		.addr_instr_i     (addr_instr_i),
		.rs1_data_i       (rs1_data),
		.rs2_data_i       (rs2_data),
		.ex_result_i      (ex_result),
		.rs1_addr_o       (rs1_addr),
		.rs2_addr_o       (rs2_addr),
		.jmp_flag_o       (jmp_flag_o),
		.jmp_target_o     (jmp_target_o),
		.ex_rd_o          (ex_rd),
		.ex_wr_en_o       (ex_wr_en),
		.alu_operation_o  (alu_operation),
		.word_intercept_o (word_intercept),
		.alu_op_num1_o    (alu_op_num1),
		.alu_op_num2_o    (alu_op_num2)
	);

	ex_alu u_ex_alu (
		.clk              (clk),
		.rst_n_i          (rst_n_i),
		.rd_addr_i        (ex_rd),
		.reg_wr_en_i      (ex_wr_en),
		.alu_operation_i  (alu_operation),
		.word_intercept_i (word_intercept),
		.alu_op_num1_i    (alu_op_num1),
		.alu_op_num2_i    (alu_op_num2),
		.result_o         (ex_result),
		.rf_wr_en_o       (rf_wr_en),
		.rf_wr_addr_o     (rf_wr_addr),
		.rf_wr_data_o     (rf_wr_data),
		.wb_en_o          (wb_en_o),
		.wb_addr_o        (wb_addr_o),
		.wb_data_o        (wb_data_o)
	);

endmodule

/* src/ex_alu.sv */
// --------------------------------------------------------------------------
// Execute stage ALU.
// Computes the result, writes the register file and registers the
// write-back onto the outputs. Word forms sign-extend bit 31.
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module ex_alu (
	input  logic                          clk,
	input  logic                          rst_n_i,
	input  logic [rv_pkg::REG_ADDR_W-1:0] rd_addr_i,
	input  logic                          reg_wr_en_i,
	input  rv_pkg::alu_op_e               alu_operation_i,
	input  logic                          word_intercept_i,
	input  logic [rv_pkg::XLEN-1:0]       alu_op_num1_i,
	input  logic [rv_pkg::XLEN-1:0]       alu_op_num2_i,
	output logic [rv_pkg::XLEN-1:0]       result_o,
	output logic                          rf_wr_en_o,
	output logic [rv_pkg::REG_ADDR_W-1:0] rf_wr_addr_o,
	output logic [rv_pkg::XLEN-1:0]       rf_wr_data_o,
	output logic                          wb_en_o,
	output logic [rv_pkg::REG_ADDR_W-1:0] wb_addr_o,
	output logic [rv_pkg::XLEN-1:0]       wb_data_o
);
	import rv_pkg::*;

	logic [XLEN-1:0] a, b;
	logic [XLEN-1:0] res64;
	logic [31:0]     res32;

	assign a = alu_op_num1_i;
	assign b = alu_op_num2_i;

	always_comb begin
		case (alu_operation_i)
			ALU_ADD:    res64 = a + b;
			ALU_SUB:    res64 = a - b;
			ALU_SLL:    res64 = a << b[5:0];
			ALU_SLT:    res64 = XLEN'($signed(a) < $signed(b));
			ALU_SLTU:   res64 = XLEN'(a < b);
			ALU_XOR:    res64 = a ^ b;
			ALU_SRL:    res64 = a >> b[5:0];
			ALU_SRA:    res64 = $signed(a) >>> b[5:0];
			ALU_OR:     res64 = a | b;
			ALU_AND:    res64 = a & b;
			default:    res64 = b;	// PASS_B.
		endcase
		// Word forms use the low half and a 5-bit shift amount.
		case (alu_operation_i)
			ALU_SUB: res32 = a[31:0] - b[31:0];
			ALU_SLL: res32 = a[31:0] << b[4:0];
			ALU_SRL: res32 = a[31:0] >> b[4:0];
			ALU_SRA: res32 = $signed(a[31:0]) >>> b[4:0];
			default: res32 = a[31:0] + b[31:0];
		endcase
		result_o = word_intercept_i ? {{32{res32[31]}}, res32} : res64;
	end

	assign rf_wr_en_o   = reg_wr_en_i;
	assign rf_wr_addr_o = rd_addr_i;
	assign rf_wr_data_o = result_o;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			wb_en_o   <= 1'b0;
			wb_addr_o <= '0;
			wb_data_o <= '0;
		end else begin
			wb_en_o   <= rf_wr_en_o;
			wb_addr_o <= rf_wr_addr_o;
			wb_data_o <= rf_wr_data_o;
		end
	end

	// Word forms exist only for add, subtract and the shifts.
	a_word_op: assert property (@(posedge clk) disable iff (!rst_n_i)
		(word_intercept_i && reg_wr_en_i) |->
			alu_operation_i inside {ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SRA})
		else $error("unsupported word operation in execute");

endmodule

/* src/id_stage.sv */
// --------------------------------------------------------------------------
// Instruction decode stage.
// Derives the stage hold from the hold code and joins decoder and
// the decode to execute register.
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module id_stage (
	input  logic                          clk,
	input  logic                          rst_n_i,
	input  rv_pkg::hold_code_e            hold_code_i,
	input  logic [rv_pkg::INSTR_W-1:0]    instr_i,
	input  logic [rv_pkg::XLEN-1:0]       addr_instr_i,
	input  logic [rv_pkg::XLEN-1:0]       rs1_data_i,
	input  logic [rv_pkg::XLEN-1:0]       rs2_data_i,
	input  logic [rv_pkg::XLEN-1:0]       ex_result_i,
	output logic [rv_pkg::REG_ADDR_W-1:0] rs1_addr_o,
	output logic [rv_pkg::REG_ADDR_W-1:0] rs2_addr_o,
	output logic                          jmp_flag_o,
	output logic [rv_pkg::XLEN-1:0]       jmp_target_o,
	output logic [rv_pkg::REG_ADDR_W-1:0] ex_rd_o,
	output logic                          ex_wr_en_o,
	output rv_pkg::alu_op_e               alu_operation_o,
	output logic                          word_intercept_o,
	output logic [rv_pkg::XLEN-1:0]       alu_op_num1_o,
	output logic [rv_pkg::XLEN-1:0]       alu_op_num2_o
);
	import rv_pkg::*;

	logic                  hold;
	logic [REG_ADDR_W-1:0] rd_addr;
	logic                  reg_wr_en;
	alu_op_e               alu_operation;
	logic                  word_intercept;
	logic [XLEN-1:0]       alu_op_num1;
	logic [XLEN-1:0]       alu_op_num2;

	assign hold = (hold_code_i >= HOLD_ID);	// Decode level and above.

	decoder id_decoder (
		.instr_i          (instr_i),
		.addr_instr_i     (addr_instr_i),
		.rs1_data_i       (rs1_data_i),
		.rs2_data_i       (rs2_data_i),
		.ex_result_i      (ex_result_i),
		.ex_rd_i          (ex_rd_o),
		.ex_wr_en_i       (ex_wr_en_o),
		.rs1_addr_o       (rs1_addr_o),
		.rs2_addr_o       (rs2_addr_o),
		.rd_addr_o        (rd_addr),
		.reg_wr_en_o      (reg_wr_en),
		.alu_operation_o  (alu_operation),
		.word_intercept_o (word_intercept),
		.alu_op_num1_o    (alu_op_num1),
		.alu_op_num2_o    (alu_op_num2),
		.jmp_flag_o       (jmp_flag_o),
		.jmp_target_o     (jmp_target_o)
	);

	id_ex pipeline_id_ex (
		.clk              (clk),
		.rst_n_i          (rst_n_i),
		.hold_i           (hold),
		.rd_addr_i        (rd_addr),
		.reg_wr_en_i      (reg_wr_en),
		.alu_operation_i  (alu_operation),
		.word_intercept_i (word_intercept),
		.alu_op_num1_i    (alu_op_num1),
		.alu_op_num2_i    (alu_op_num2),
		.rd_addr_o        (ex_rd_o),
		.reg_wr_en_o      (ex_wr_en_o),
		.alu_operation_o  (alu_operation_o),
		.word_intercept_o (word_intercept_o),
		.alu_op_num1_o    (alu_op_num1_o),
		.alu_op_num2_o    (alu_op_num2_o)
	);

endmodule

/* src/id_ex.sv */
// --------------------------------------------------------------------------
// Decode to execute pipeline register.
// Loads a bubble on reset or while decode is held.
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module id_ex (
	input  logic                          clk,
	input  logic                          rst_n_i,
	input  logic                          hold_i,
	input  logic [rv_pkg::REG_ADDR_W-1:0] rd_addr_i,
	input  logic                          reg_wr_en_i,
	input  rv_pkg::alu_op_e               alu_operation_i,
	input  logic                          word_intercept_i,
	input  logic [rv_pkg::XLEN-1:0]       alu_op_num1_i,
	input  logic [rv_pkg::XLEN-1:0]       alu_op_num2_i,
	output logic [rv_pkg::REG_ADDR_W-1:0] rd_addr_o,
	output logic                          reg_wr_en_o,
	output rv_pkg::alu_op_e               alu_operation_o,
	output logic                          word_intercept_o,
	output logic [rv_pkg::XLEN-1:0]       alu_op_num1_o,
	output logic [rv_pkg::XLEN-1:0]       alu_op_num2_o
);

	always_ff @(posedge clk) begin
		if (!rst_n_i || hold_i) begin
			reg_wr_en_o <= 1'b0;	// Bubble.
			rd_addr_o   <= '0;
		end else begin
			reg_wr_en_o <= reg_wr_en_i;
			rd_addr_o   <= rd_addr_i;
		end
	end

	always_ff @(posedge clk) begin
		alu_operation_o  <= alu_operation_i;
		word_intercept_o <= word_intercept_i;
		alu_op_num1_o    <= alu_op_num1_i;
		alu_op_num2_o    <= alu_op_num2_i;
	end

	// A write to x0 would be forwarded by the decoder as a live value.
	a_no_x0_enable: assert property (@(posedge clk) disable iff (!rst_n_i)
		reg_wr_en_o |-> rd_addr_o != '0)
		else $error("execute write enable set with rd == x0");

endmodule

/* src/decoder.sv */
// --------------------------------------------------------------------------
// Combinational RV64I instruction decoder.
// Builds immediates, bypasses the execute result, selects ALU operation
// and operands, and resolves branches and jumps in the same cycle.
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module decoder (
	input  logic [rv_pkg::INSTR_W-1:0]    instr_i,
	input  logic [rv_pkg::XLEN-1:0]       addr_instr_i,
	input  logic [rv_pkg::XLEN-1:0]       rs1_data_i,
	input  logic [rv_pkg::XLEN-1:0]       rs2_data_i,
	input  logic [rv_pkg::XLEN-1:0]       ex_result_i,
	input  logic [rv_pkg::REG_ADDR_W-1:0] ex_rd_i,
	input  logic                          ex_wr_en_i,
	output logic [rv_pkg::REG_ADDR_W-1:0] rs1_addr_o,
	output logic [rv_pkg::REG_ADDR_W-1:0] rs2_addr_o,
	output logic [rv_pkg::REG_ADDR_W-1:0] rd_addr_o,
	output logic                          reg_wr_en_o,
	output rv_pkg::alu_op_e               alu_operation_o,
	output logic                          word_intercept_o,
	output logic [rv_pkg::XLEN-1:0]       alu_op_num1_o,
	output logic [rv_pkg::XLEN-1:0]       alu_op_num2_o,
	output logic                          jmp_flag_o,
	output logic [rv_pkg::XLEN-1:0]       jmp_target_o
);
	import rv_pkg::*;

	opcode_e         opcode;
	logic [2:0]      funct3;
	logic [XLEN-1:0] imm_i, imm_u, imm_b, imm_j;
	logic [XLEN-1:0] rs1_val, rs2_val;
	logic            shift_alt;
	logic            word_f3_ok;
	logic            wr_en;
	logic            taken;
	logic [XLEN-1:0] target;

	function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000:  arith_op = alt ? ALU_SUB : ALU_ADD;
			3'b001:  arith_op = ALU_SLL;
			3'b010:  arith_op = ALU_SLT;
			3'b011:  arith_op = ALU_SLTU;
			3'b100:  arith_op = ALU_XOR;
			3'b101:  arith_op = alt ? ALU_SRA : ALU_SRL;
			3'b110:  arith_op = ALU_OR;
			default: arith_op = ALU_AND;
		endcase
	endfunction

	assign opcode     = opcode_e'(instr_i[6:0]);
	assign funct3     = instr_i[14:12];
	assign rd_addr_o  = instr_i[11:7];
	assign rs1_addr_o = instr_i[19:15];
	assign rs2_addr_o = instr_i[24:20];

	assign imm_i = {{(XLEN-12){instr_i[31]}}, instr_i[31:20]};
	assign imm_u = {{(XLEN-32){instr_i[31]}}, instr_i[31:12], 12'b0};
	assign imm_b = {{(XLEN-12){instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
	assign imm_j = {{(XLEN-20){instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

	// Execute result overrides the register file except for x0.
	assign rs1_val = (ex_wr_en_i && ex_rd_i == rs1_addr_o && rs1_addr_o != '0) ?
		ex_result_i : rs1_data_i;
	assign rs2_val = (ex_wr_en_i && ex_rd_i == rs2_addr_o && rs2_addr_o != '0) ?
		ex_result_i : rs2_data_i;

	assign shift_alt  = instr_i[30] & (funct3 == 3'b101);	// No SUBI.
	assign word_f3_ok = (funct3 == 3'b000) || (funct3 == 3'b001) || (funct3 == 3'b101);

	always_comb begin
		alu_operation_o  = ALU_ADD;
		word_intercept_o = 1'b0;
		alu_op_num1_o    = rs1_val;
		alu_op_num2_o    = imm_i;
		wr_en            = 1'b0;
		taken            = 1'b0;
		target           = '0;
		case (opcode)
			OP_LUI: begin
				alu_operation_o = ALU_PASS_B;
				alu_op_num2_o   = imm_u;
				wr_en           = 1'b1;
			end
			OP_AUIPC: begin
				alu_op_num1_o = addr_instr_i;
				alu_op_num2_o = imm_u;
				wr_en         = 1'b1;
			end
			OP_JAL: begin
				alu_op_num1_o = addr_instr_i;
				alu_op_num2_o = XLEN'(4);	// Link address.
				wr_en         = 1'b1;
				taken         = 1'b1;
				target        = addr_instr_i + imm_j;
			end
			OP_JALR: begin
				alu_op_num1_o = addr_instr_i;
				alu_op_num2_o = XLEN'(4);
				wr_en         = 1'b1;
				taken         = 1'b1;
				target        = (rs1_val + imm_i) & ~XLEN'(1);
			end
			OP_BRANCH: begin
				case (funct3)
					3'b000:  taken = (rs1_val == rs2_val);
					3'b001:  taken = (rs1_val != rs2_val);
					3'b100:  taken = ($signed(rs1_val) < $signed(rs2_val));
					3'b101:  taken = ($signed(rs1_val) >= $signed(rs2_val));
					3'b110:  taken = (rs1_val < rs2_val);
					3'b111:  taken = (rs1_val >= rs2_val);
					default: taken = 1'b0;
				endcase
				target = addr_instr_i + imm_b;
			end
			OP_IMM: begin
				alu_operation_o = arith_op(funct3, shift_alt);
				wr_en           = 1'b1;
			end
			OP_REG: begin
				alu_operation_o = arith_op(funct3, instr_i[30]);
				alu_op_num2_o   = rs2_val;
				wr_en           = 1'b1;
			end
			OP_IMM32: begin
				alu_operation_o  = arith_op(funct3, shift_alt);
				word_intercept_o = 1'b1;
				wr_en            = word_f3_ok;
			end
			OP_REG32: begin
				alu_operation_o  = arith_op(funct3, instr_i[30]);
				word_intercept_o = 1'b1;
				alu_op_num2_o    = rs2_val;
				wr_en            = word_f3_ok;
			end
			default: wr_en = 1'b0;	// Loads, stores and system become a bubble.
		endcase
	end

	assign reg_wr_en_o  = wr_en && (rd_addr_o != '0);
	assign jmp_flag_o   = taken;
	assign jmp_target_o = taken ? target : '0;

endmodule

/* src/regfile.sv */
// --------------------------------------------------------------------------
// Integer register file, 32 entries of XLEN bits.
// Two combinational read ports, one synchronous write port, x0 reads zero.
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module regfile (
	input  logic                          clk,
	input  logic                          rst_n_i,
	input  logic [rv_pkg::REG_ADDR_W-1:0] rs1_addr_i,
	input  logic [rv_pkg::REG_ADDR_W-1:0] rs2_addr_i,
	output logic [rv_pkg::XLEN-1:0]       rs1_data_o,
	output logic [rv_pkg::XLEN-1:0]       rs2_data_o,
	input  logic                          wr_en_i,
	input  logic [rv_pkg::REG_ADDR_W-1:0] wr_addr_i,
	input  logic [rv_pkg::XLEN-1:0]       wr_data_i
);
	import rv_pkg::*;

	logic [XLEN-1:0] regs [32];

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en_i && wr_addr_i != '0) begin
			regs[wr_addr_i] <= wr_data_i;
		end
	end

	assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
	assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

	// The decoder suppresses rd == x0, so execute never asks for it.
	a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n_i)
		wr_en_i |-> wr_addr_i != '0)
		else $error("register file write to x0 requested");

endmodule

/* src/rv_pkg.sv */
// --------------------------------------------------------------------------
// RV64I decode/execute slice: shared widths and encodings.
// Major opcodes, execute operations and the ordered pipeline hold code.
// --------------------------------------------------------------------------
package rv_pkg;

	localparam int XLEN       = 64;	// Register data width.
	localparam int REG_ADDR_W = 5;
	localparam int INSTR_W    = 32;

	// Major opcodes as encoded in the instruction set.
	typedef enum logic [6:0] {
		OP_LUI    = 7'b0110111,
		OP_AUIPC  = 7'b0010111,
		OP_JAL    = 7'b1101111,
		OP_JALR   = 7'b1100111,
		OP_BRANCH = 7'b1100011,
		OP_IMM    = 7'b0010011,
		OP_REG    = 7'b0110011,
		OP_IMM32  = 7'b0011011,
		OP_REG32  = 7'b0111011
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		ALU_PASS_B	// LUI.
	} alu_op_e;

	// Ordered so that a stage is held at or above its own level.
	typedef enum logic [1:0] {
		HOLD_NONE = 2'd0,
		HOLD_IF   = 2'd1,
		HOLD_ID   = 2'd2,
		HOLD_EX   = 2'd3
	} hold_code_e;

endpackage
